// ==== logic/cheri_defs.svh ====
/*
 * operator vector width and default configuration bits
 * for the CHERI decode slice
 */
`ifndef CHERI_DEFS_SVH
`define CHERI_DEFS_SVH

// one bit per decoded operator, top bit is a spare slot
`define CHERI_OPDW 33

// pipelined capability load, off by default
`define CHERI_PPLBC_DEF 1'b0
// two-cycle set-bounds, on by default
`define CHERI_SBND2_DEF 1'b1

`endif

// ==== logic/cheri_pkg.sv ====
/*
 * shared types for the CHERI decode slice: operator index enum,
 * operator vector, instruction, immediate and register index types
 */
`include "cheri_defs.svh"

package cheri_pkg;

  // raw instruction word and its extended immediate
  typedef logic [31:0] instr_t;
  typedef logic [31:0] imm_t;

  // register or special capability register index
  typedef logic [4:0] reg_addr_t;

  // one-hot operator vector, indexed by cheri_op_e
  typedef logic [`CHERI_OPDW-1:0] cheri_opvec_t;

  // bit positions inside cheri_opvec_t
  typedef enum logic [5:0] {
    // register format, funct3 = 0, funct7 selects
    CCSR_RW,
    CSET_BOUNDS,
    CSET_BOUNDS_EX,
    CSEAL,
    CUNSEAL,
    CAND_PERM,
    CSET_ADDR,
    CINC_ADDR,
    CSUB_CAP,
    CSET_HIGH,
    CIS_SUBSET,
    CIS_EQUAL,
    // get/move format, funct7 = 0x7f, imm5 selects
    CGET_PERM,
    CGET_TYPE,
    CGET_BASE,
    CGET_HIGH,
    CGET_TOP,
    CGET_LEN,
    CGET_TAG,
    CRRL,
    CRAM,
    CGET_ADDR,
    CMOVE_CAP,
    CCLEAR_TAG,
    // immediate format, funct3 selects
    CINC_ADDR_IMM,
    CSET_BOUNDS_IMM,
    // capability forms of base opcodes
    CAUIPCC,
    CAUICGP,
    CJALR,
    CJAL,
    CLOAD_CAP,
    CSTORE_CAP
  } cheri_op_e;

endpackage

// ==== logic/cheri_predecoder.sv ====
/*
 * major opcode predecode into CHERI instruction class enables,
 * qualified by capability mode
 */
`timescale 1ns/1ns

module cheri_predecoder import cheri_pkg::*; (
  input  instr_t instr_i,
  input  logic   cheri_pmode_i,
  output logic   opcode_en_o,
  output logic   auipcc_en_o,
  output logic   auicgp_en_o,
  output logic   jalr_en_o,
  output logic   jal_en_o,
  output logic   cload_en_o,
  output logic   cstore_en_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       funct3_dword;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];

  // capability load/store reuse the LD/SD width code
  assign funct3_dword = (funct3 == 3'd3);

  always_comb begin
    opcode_en_o = 1'b0;
    auipcc_en_o = 1'b0;
    auicgp_en_o = 1'b0;
    jalr_en_o   = 1'b0;
    jal_en_o    = 1'b0;
    cload_en_o  = 1'b0;
    cstore_en_o = 1'b0;

    // integer mode never sees a CHERI instruction
    if (cheri_pmode_i) begin
      case (opcode)
        7'h5b: opcode_en_o = 1'b1;
        7'h17: auipcc_en_o = 1'b1;
        7'h7b: auicgp_en_o = 1'b1;
        7'h67: jalr_en_o   = 1'b1;
        7'h6f: jal_en_o    = 1'b1;
        7'h03: cload_en_o  = funct3_dword;
        7'h23: cstore_en_o = funct3_dword;
        default: begin
          opcode_en_o = 1'b0;
        end
      endcase
    end
  end

endmodule

// ==== logic/cheri_decoder.sv ====
/*
 * CHERI operator decode into a one-hot vector, plus cs2 index,
 * register-file use flags and the multicycle hint
 */
`timescale 1ns/1ns
`include "cheri_defs.svh"

module cheri_decoder import cheri_pkg::*; #(
  parameter bit CheriPPLBC = `CHERI_PPLBC_DEF,
  parameter bit CheriSBND2 = `CHERI_SBND2_DEF
) (
  input  instr_t       instr_i,
  input  logic         opcode_en_i,
  input  logic         auipcc_en_i,
  input  logic         auicgp_en_i,
  input  logic         jalr_en_i,
  input  logic         jal_en_i,
  input  logic         cload_en_i,
  input  logic         cstore_en_i,
  input  logic         cheri_tsafe_en_i,
  output logic         instr_is_cheri_o,
  output logic         instr_is_legal_o,
  output cheri_opvec_t operator_o,
  output reg_addr_t    cs2_o,
  output logic         rf_ren_b_o,
  output logic         rf_we_o,
  output logic         multicycle_o
);

  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [4:0] imm5;
  logic       bounds_op;

  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];
  assign imm5   = instr_i[24:20];

  // three formats share opcode 0x5b
  //   funct3 != 0           immediate ops
  //   funct3 == 0           register ops, funct7 selects
  //   funct7 == 0x7f        get/move ops, imm5 selects
  always_comb begin
    operator_o = '0;

    if (opcode_en_i) begin
      case (funct3)
        3'd0: begin
          if (funct7 == 7'h7f) begin
            case (imm5)
              5'h00: operator_o[CGET_PERM]  = 1'b1;
              5'h01: operator_o[CGET_TYPE]  = 1'b1;
              5'h02: operator_o[CGET_BASE]  = 1'b1;
              5'h03: operator_o[CGET_LEN]   = 1'b1;
              5'h04: operator_o[CGET_TAG]   = 1'b1;
              5'h08: operator_o[CRRL]       = 1'b1;
              5'h09: operator_o[CRAM]       = 1'b1;
              5'h0a: operator_o[CMOVE_CAP]  = 1'b1;
              5'h0b: operator_o[CCLEAR_TAG] = 1'b1;
              5'h0f: operator_o[CGET_ADDR]  = 1'b1;
              5'h17: operator_o[CGET_HIGH]  = 1'b1;
              5'h18: operator_o[CGET_TOP]   = 1'b1;
              default: ;
            endcase
          end else begin
            case (funct7)
              7'h01: operator_o[CCSR_RW]        = 1'b1;
              7'h08: operator_o[CSET_BOUNDS]    = 1'b1;
              7'h09: operator_o[CSET_BOUNDS_EX] = 1'b1;
              7'h0b: operator_o[CSEAL]          = 1'b1;
              7'h0c: operator_o[CUNSEAL]        = 1'b1;
              7'h0d: operator_o[CAND_PERM]      = 1'b1;
              7'h10: operator_o[CSET_ADDR]      = 1'b1;
              7'h11: operator_o[CINC_ADDR]      = 1'b1;
              7'h14: operator_o[CSUB_CAP]       = 1'b1;
              7'h16: operator_o[CSET_HIGH]      = 1'b1;
              7'h20: operator_o[CIS_SUBSET]     = 1'b1;
              7'h21: operator_o[CIS_EQUAL]      = 1'b1;
              default: ;
            endcase
          end
        end
        3'd1:    operator_o[CINC_ADDR_IMM]   = 1'b1;
        3'd2:    operator_o[CSET_BOUNDS_IMM] = 1'b1;
        default: ;
      endcase
    end

    // base-opcode forms map one to one
    operator_o[CAUIPCC]    = auipcc_en_i;
    operator_o[CAUICGP]    = auicgp_en_i;
    operator_o[CJALR]      = jalr_en_i;
    operator_o[CJAL]       = jal_en_i;
    operator_o[CLOAD_CAP]  = cload_en_i;
    operator_o[CSTORE_CAP] = cstore_en_i;
  end

  assign instr_is_cheri_o = opcode_en_i | auipcc_en_i | auicgp_en_i | jalr_en_i |
                            jal_en_i | cload_en_i | cstore_en_i;

  assign instr_is_legal_o = |operator_o;

  // special capability register index for CSpecialRW
  assign cs2_o = operator_o[CCSR_RW] ? imm5 : '0;

  // early read hint, taken from fields only so it stays off the opcode path
  assign rf_ren_b_o = (funct3 == 3'd0) && (funct7 != 7'h7f);

  // stores are the only class with no destination
  assign rf_we_o = opcode_en_i | auipcc_en_i | auicgp_en_i | jalr_en_i |
                   jal_en_i | cload_en_i;

  assign bounds_op = operator_o[CSET_BOUNDS] | operator_o[CSET_BOUNDS_EX] |
                     operator_o[CSET_BOUNDS_IMM] | operator_o[CRRL] | operator_o[CRAM];

  assign multicycle_o = (operator_o[CLOAD_CAP] & cheri_tsafe_en_i & ~CheriPPLBC) |
                        (CheriSBND2 & bounds_op);

endmodule

// ==== logic/cheri_imm_select.sv ====
/*
 * immediate assembly for CHERI operators, one 32-bit value
 * from the I, S, U or J field layout
 */
`timescale 1ns/1ns

module cheri_imm_select import cheri_pkg::*; (
  input  instr_t       instr_i,
  input  cheri_opvec_t operator_i,
  output imm_t         imm_o
);

  logic [11:0] i_field;
  logic [11:0] s_field;
  logic [19:0] u_field;
  logic [20:0] j_field;
  logic        i_signed_op;

  assign i_field = instr_i[31:20];
  assign s_field = {instr_i[31:25], instr_i[11:7]};
  assign u_field = instr_i[31:12];

  // jump offset, bit 0 always zero
  assign j_field = {instr_i[31], instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

  assign i_signed_op = operator_i[CJALR] | operator_i[CINC_ADDR_IMM] |
                       operator_i[CLOAD_CAP];

  always_comb begin
    imm_o = '0;

    if (i_signed_op) begin
      imm_o = {{20{i_field[11]}}, i_field};
    end else if (operator_i[CSET_BOUNDS_IMM]) begin
      // length operand is unsigned
      imm_o = {20'h0, i_field};
    end else if (operator_i[CSTORE_CAP]) begin
      imm_o = {{20{s_field[11]}}, s_field};
    end else if (operator_i[CAUIPCC] | operator_i[CAUICGP]) begin
      imm_o = {u_field, 12'h0};
    end else if (operator_i[CJAL]) begin
      imm_o = {{11{j_field[20]}}, j_field};
    end
  end

endmodule

// ==== logic/cheri_decode_unit.sv ====
/*
 * CHERI decode slice top: predecode, operator decode and
 * immediate select, followed by one output register stage
 */
`timescale 1ns/1ns

module cheri_decode_unit import cheri_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  logic         instr_valid_i,
  input  instr_t       instr_rdata_i,
  input  logic         cheri_pmode_i,
  input  logic         cheri_tsafe_en_i,
  output logic         dec_valid_o,
  output logic         instr_is_cheri_o,
  output logic         instr_is_legal_o,
  output cheri_opvec_t operator_o,
  output imm_t         imm_o,
  output reg_addr_t    cs2_o,
  output logic         rf_ren_b_o,
  output logic         rf_we_o,
  output logic         multicycle_o
);

  // class enables
  logic opcode_en;
  logic auipcc_en;
  logic auicgp_en;
  logic jalr_en;
  logic jal_en;
  logic cload_en;
  logic cstore_en;

  // combinational decode results
  logic         is_cheri_d;
  logic         is_legal_d;
  cheri_opvec_t operator_d;
  imm_t         imm_d;
  reg_addr_t    cs2_d;
  logic         rf_ren_b_d;
  logic         rf_we_d;
  logic         multicycle_d;

  cheri_predecoder u_predecoder (
    .instr_i       (instr_rdata_i),
    .cheri_pmode_i (cheri_pmode_i),
    .opcode_en_o   (opcode_en),
    .auipcc_en_o   (auipcc_en),
    .auicgp_en_o   (auicgp_en),
    .jalr_en_o     (jalr_en),
    .jal_en_o      (jal_en),
    .cload_en_o    (cload_en),
    .cstore_en_o   (cstore_en)
  );

  cheri_decoder u_decoder (
    .instr_i          (instr_rdata_i),
    .opcode_en_i      (opcode_en),
    .auipcc_en_i      (auipcc_en),
    .auicgp_en_i      (auicgp_en),
    .jalr_en_i        (jalr_en),
    .jal_en_i         (jal_en),
    .cload_en_i       (cload_en),
    .cstore_en_i      (cstore_en),
    .cheri_tsafe_en_i (cheri_tsafe_en_i),
    .instr_is_cheri_o (is_cheri_d),
    .instr_is_legal_o (is_legal_d),
    .operator_o       (operator_d),
    .cs2_o            (cs2_d),
    .rf_ren_b_o       (rf_ren_b_d),
    .rf_we_o          (rf_we_d),
    .multicycle_o     (multicycle_d)
  );

  cheri_imm_select u_imm_select (
    .instr_i    (instr_rdata_i),
    .operator_i (operator_d),
    .imm_o      (imm_d)
  );

  // valid pulse follows the input strobe by one cycle
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      dec_valid_o <= 1'b0;
    end else begin
      dec_valid_o <= instr_valid_i;
    end
  end

  // results only load on a strobe, otherwise hold
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      instr_is_cheri_o <= 1'b0;
      instr_is_legal_o <= 1'b0;
      operator_o       <= '0;
      imm_o            <= '0;
      cs2_o            <= '0;
      rf_ren_b_o       <= 1'b0;
      rf_we_o          <= 1'b0;
      multicycle_o     <= 1'b0;
    end else if (instr_valid_i) begin
      instr_is_cheri_o <= is_cheri_d;
      instr_is_legal_o <= is_legal_d;
      operator_o       <= operator_d;
      imm_o            <= imm_d;
      cs2_o            <= cs2_d;
      rf_ren_b_o       <= rf_ren_b_d;
      rf_we_o          <= rf_we_d;
      multicycle_o     <= multicycle_d;
    end
  end

endmodule

// ==== tb/tb_cheri_decode_unit.sv ====
/*
 * self-checking testbench for the CHERI decode unit: directed vectors
 * from a data file, then a back-to-back random pass in integer mode
 */
`timescale 1ns/1ns

module tb_cheri_decode_unit import cheri_pkg::*; ();

  localparam int RAND_COUNT = 64;

  logic         clk_i;
  logic         rst_n_i;
  logic         instr_valid_i;
  instr_t       instr_rdata_i;
  logic         cheri_pmode_i;
  logic         cheri_tsafe_en_i;
  logic         dec_valid_o;
  logic         instr_is_cheri_o;
  logic         instr_is_legal_o;
  cheri_opvec_t operator_o;
  imm_t         imm_o;
  reg_addr_t    cs2_o;
  logic         rf_ren_b_o;
  logic         rf_we_o;
  logic         multicycle_o;

  logic [31:0] rng_state = 32'h4887_585d;
  integer      check_errors = 0;
  integer      test_count = 0;
  integer      failed_tests = 0;
  logic        timed_out = 1'b0;
  logic        setup_error = 1'b0;

  cheri_decode_unit DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // read-port B hint depends on funct3 and funct7 only
  function automatic logic expected_ren_b(input instr_t instr);
    return (instr[14:12] == 3'd0) && (instr[31:25] != 7'h7f);
  endfunction

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s got %b expected %b", $time, what, got, exp);
      check_errors++;
    end
  endtask

  task automatic check_opvec(input cheri_opvec_t got, input cheri_opvec_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: operator got %h expected %h", $time, got, exp);
      check_errors++;
    end
  endtask

  task automatic check_imm(input imm_t got, input imm_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: imm got %h expected %h", $time, got, exp);
      check_errors++;
    end
  endtask

  task automatic check_reg(input reg_addr_t got, input reg_addr_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: cs2 got %h expected %h", $time, got, exp);
      check_errors++;
    end
  endtask

  task automatic check_all(input logic valid, input logic cheri, input logic legal,
                           input cheri_opvec_t op, input imm_t imm, input reg_addr_t cs2,
                           input logic ren_b, input logic we, input logic mc);
    check_bit(dec_valid_o, valid, "dec_valid_o");
    check_bit(instr_is_cheri_o, cheri, "instr_is_cheri_o");
    check_bit(instr_is_legal_o, legal, "instr_is_legal_o");
    check_opvec(operator_o, op);
    check_imm(imm_o, imm);
    check_reg(cs2_o, cs2);
    check_bit(rf_ren_b_o, ren_b, "rf_ren_b_o");
    check_bit(rf_we_o, we, "rf_we_o");
    check_bit(multicycle_o, mc, "multicycle_o");
  endtask

  task automatic report_test(input string name, input integer errs_before);
    test_count++;
    if (check_errors != errs_before || timed_out) begin
      failed_tests++;
      $display("test %0d (%s): mismatch", test_count, name);
    end else begin
      $display("test %0d (%s): ok", test_count, name);
    end
  endtask

  task automatic wait_for_result();
    integer cycles;
    cycles = 0;
    @(negedge clk_i);
    while (!dec_valid_o && cycles < 20) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!dec_valid_o) begin
      $display("ERROR at %0t ns: no decode result within timeout", $time);
      timed_out = 1'b1;
    end
  endtask

  task automatic run_vector(input instr_t instr, input logic pmode, input logic tsafe,
                            input logic cheri, input logic legal, input integer op_idx,
                            input imm_t imm, input reg_addr_t cs2, input logic ren_b,
                            input logic we, input logic mc);
    cheri_opvec_t exp_op;
    integer       errs_before;
    exp_op = '0;
    if (op_idx >= 0) begin
      exp_op[op_idx] = 1'b1;
    end
    errs_before = check_errors;
    @(posedge clk_i);
    instr_valid_i    <= 1'b1;
    instr_rdata_i    <= instr;
    cheri_pmode_i    <= pmode;
    cheri_tsafe_en_i <= tsafe;
    @(posedge clk_i);
    instr_valid_i <= 1'b0;
    // a different word while the strobe is low must not reach the outputs
    instr_rdata_i <= ~instr;
    wait_for_result();
    if (!timed_out) begin
      check_all(1'b1, cheri, legal, exp_op, imm, cs2, ren_b, we, mc);
      // one strobe gives one pulse, results hold while the strobe is low
      @(negedge clk_i);
      check_all(1'b0, cheri, legal, exp_op, imm, cs2, ren_b, we, mc);
    end
    report_test($sformatf("instr %h", instr), errs_before);
  endtask

  // strobes on every cycle, results checked one cycle behind
  task automatic run_random_pass();
    instr_t instr_q[$];
    instr_t cur;
    integer errs_before;
    integer i;
    errs_before = check_errors;
    for (i = 0; i <= RAND_COUNT; i++) begin
      @(posedge clk_i);
      if (i < RAND_COUNT) begin
        rng_state = xorshift32(rng_state);
        instr_valid_i    <= 1'b1;
        instr_rdata_i    <= rng_state;
        cheri_pmode_i    <= 1'b0;
        cheri_tsafe_en_i <= rng_state[7];
        instr_q.push_back(rng_state);
      end else begin
        instr_valid_i <= 1'b0;
      end
      if (i > 0) begin
        @(negedge clk_i);
        cur = instr_q.pop_front();
        check_all(1'b1, 1'b0, 1'b0, '0, '0, '0, expected_ren_b(cur), 1'b0, 1'b0);
      end
    end
    @(negedge clk_i);
    check_bit(dec_valid_o, 1'b0, "dec_valid_o after last strobe");
    report_test("random integer-mode pass", errs_before);
  endtask

  initial begin
    integer       fd;
    integer       n;
    integer       errs_before;
    logic [1023:0] line_buf;
    instr_t       v_instr;
    logic         v_pmode;
    logic         v_tsafe;
    logic         v_cheri;
    logic         v_legal;
    logic         v_ren;
    logic         v_we;
    logic         v_mc;
    integer       v_op;
    imm_t         v_imm;
    reg_addr_t    v_cs2;

    rst_n_i          = 1'b0;
    instr_valid_i    = 1'b0;
    instr_rdata_i    = '0;
    cheri_pmode_i    = 1'b0;
    cheri_tsafe_en_i = 1'b0;
    repeat (10) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    errs_before = check_errors;
    check_all(1'b0, 1'b0, 1'b0, '0, '0, '0, 1'b0, 1'b0, 1'b0);
    report_test("outputs after reset", errs_before);

    fd = $fopen("tb/cheri_decode_tests.txt", "r");
    if (fd == 0) begin
      $display("ERROR: could not open the test vector file tb/cheri_decode_tests.txt");
      setup_error = 1'b1;
    end else begin
      while (!$feof(fd) && !timed_out) begin
        line_buf = '0;
        n = $fgets(line_buf, fd);
        // comment and blank lines match no fields
        n = $sscanf(line_buf, "%h %h %h %h %h %d %h %h %h %h %h", v_instr, v_pmode, v_tsafe,
                    v_cheri, v_legal, v_op, v_imm, v_cs2, v_ren, v_we, v_mc);
        if (n == 11) begin
          run_vector(v_instr, v_pmode, v_tsafe, v_cheri, v_legal, v_op, v_imm, v_cs2,
                     v_ren, v_we, v_mc);
        end
      end
      $fclose(fd);
    end

    if (!timed_out) begin
      run_random_pass();
    end

    $display("tests run %0d, tests failed %0d, check errors %0d", test_count, failed_tests,
             check_errors);
    if (check_errors == 0 && failed_tests == 0 && !timed_out && !setup_error) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== tb/cheri_decode_tests.txt ====
# instr pmode tsafe | is_cheri legal op_index (-1 none) | imm cs2 rf_ren_b rf_we multicycle
# all hex except op_index, which is decimal
03c100db 1 0  1 1  0  00000000 1c 1 1 0
103100db 1 0  1 1  1  00000000 00 1 1 1
123100db 1 0  1 1  2  00000000 00 1 1 1
163100db 1 0  1 1  3  00000000 00 1 1 0
183100db 1 0  1 1  4  00000000 00 1 1 0
1a3100db 1 0  1 1  5  00000000 00 1 1 0
203100db 1 0  1 1  6  00000000 00 1 1 0
223100db 1 0  1 1  7  00000000 00 1 1 0
283100db 1 0  1 1  8  00000000 00 1 1 0
2c3100db 1 0  1 1  9  00000000 00 1 1 0
403100db 1 0  1 1 10  00000000 00 1 1 0
423100db 1 0  1 1 11  00000000 00 1 1 0
fe0100db 1 0  1 1 12  00000000 00 0 1 0
fe1100db 1 0  1 1 13  00000000 00 0 1 0
fe2100db 1 0  1 1 14  00000000 00 0 1 0
ff7100db 1 0  1 1 15  00000000 00 0 1 0
ff8100db 1 0  1 1 16  00000000 00 0 1 0
fe3100db 1 0  1 1 17  00000000 00 0 1 0
fe4100db 1 0  1 1 18  00000000 00 0 1 0
fe8100db 1 0  1 1 19  00000000 00 0 1 1
fe9100db 1 0  1 1 20  00000000 00 0 1 1
fef100db 1 0  1 1 21  00000000 00 0 1 0
fea100db 1 0  1 1 22  00000000 00 0 1 0
feb100db 1 0  1 1 23  00000000 00 0 1 0
ff8110db 1 0  1 1 24  fffffff8 00 0 1 0
800120db 1 0  1 1 25  00000800 00 0 1 1
12345097 1 0  1 1 26  12345000 00 0 1 0
fedcb0fb 1 0  1 1 27  fedcb000 00 0 1 0
7fc100e7 1 0  1 1 28  000007fc 00 1 1 0
001000ef 1 0  1 1 29  00000800 00 1 1 0
ffdff0ef 1 0  1 1 29  fffffffc 00 0 1 0
ff013083 1 1  1 1 30  fffffff0 00 0 1 1
ff013083 1 0  1 1 30  fffffff0 00 0 1 0
80313223 1 0  1 1 31  fffff804 00 0 0 0
043100db 1 0  1 0 -1  00000000 00 1 1 0
fe5100db 1 0  1 0 -1  00000000 00 0 1 0
000130db 1 0  1 0 -1  00000000 00 0 1 0
103100db 0 0  0 0 -1  00000000 00 1 0 0

// ==== sources.f ====
+incdir+logic
logic/cheri_pkg.sv
logic/cheri_predecoder.sv
logic/cheri_decoder.sv
logic/cheri_imm_select.sv
logic/cheri_decode_unit.sv
tb/tb_cheri_decode_unit.sv
